// ==== verification/ctrl_patterns.txt ====
# id: vld,ecall,mret pc rs1 rs2 rs1_val rs2_val  ex: vld,wen,ren,jump,br,fence pc imm res rd
# mem: vld,wen,ren rd alu rdata  csr: wen addr wdata  expect: rs1_in rs2_in dnpc rdy,dnv,fl,icc
000 000 00 00 000 000  000000 000 000 000 00  000 00 000 000  0 000 000  000 000 000 1000
# forwarding priority
100 000 05 06 011 022  110000 000 000 0e1 05  110 05 0a1 0d1  0 000 000  0e1 022 000 1000
100 000 05 00 011 022  110000 000 000 0e1 07  110 05 0a1 0d1  0 000 000  0a1 022 000 1000
100 000 03 05 011 022  110000 000 000 0e1 07  111 05 0a1 0d1  0 000 000  011 0d1 000 1000
100 000 00 00 011 022  110000 000 000 0e1 00  110 00 0a1 0d1  0 000 000  011 022 000 1000
100 000 05 06 011 022  010000 000 000 0e1 05  110 05 0a1 0d1  0 000 000  0a1 022 000 1000
100 000 05 06 011 022  100000 000 000 0e1 05  010 06 0a1 0d1  0 000 000  011 022 000 1000
# load-use stall
100 000 03 05 011 022  111000 000 000 0e1 05  000 00 000 000  0 000 000  011 0e1 000 0000
000 000 03 05 011 022  111000 000 000 0e1 05  000 00 000 000  0 000 000  011 0e1 000 1000
100 000 05 06 011 022  111000 000 000 0e1 05  000 00 000 000  0 000 000  0e1 022 000 0000
100 000 00 06 011 022  111000 000 000 0e1 00  000 00 000 000  0 000 000  011 022 000 1000
100 000 05 06 011 022  011000 000 000 0e1 05  000 00 000 000  0 000 000  011 022 000 1000
100 000 03 04 011 022  111000 000 000 0e1 05  000 00 000 000  0 000 000  011 022 000 1000
# ex redirects
000 000 00 00 000 000  100100 200 010 348 00  000 00 000 000  0 000 000  000 000 348 1110
000 000 00 00 000 000  100010 200 040 001 00  000 00 000 000  0 000 000  000 000 240 1110
000 000 00 00 000 000  100010 200 040 000 00  000 00 000 000  0 000 000  000 000 000 1000
000 000 00 00 000 000  100001 204 000 000 00  000 00 000 000  0 000 000  000 000 208 1111
000 000 00 00 000 000  000100 200 010 348 00  000 00 000 000  0 000 000  000 000 000 1000
000 000 00 00 000 000  000001 204 000 000 00  000 00 000 000  0 000 000  000 000 000 1000
# trap registers, ecall saves its pc
110 300 00 00 000 000  000000 000 000 000 00  000 00 000 000  0 000 000  000 000 100 1110
000 000 00 00 000 000  000000 000 000 000 00  000 00 000 000  1 305 400  000 000 000 1000
110 310 00 00 000 000  000000 000 000 000 00  000 00 000 000  0 000 000  000 000 400 1110
010 318 00 00 000 000  000000 000 000 000 00  000 00 000 000  0 000 000  000 000 000 1000
101 320 00 00 000 000  000000 000 000 000 00  000 00 000 000  0 000 000  000 000 310 1110
# ex jump beats id ecall, mepc keeps 310
110 330 00 00 000 000  100100 200 010 37c 00  000 00 000 000  0 000 000  000 000 37c 1110
101 334 00 00 000 000  000000 000 000 000 00  000 00 000 000  0 000 000  000 000 310 1110
# csr writes to mepc and a foreign address
000 000 00 00 000 000  000000 000 000 000 00  000 00 000 000  1 341 500  000 000 000 1000
101 338 00 00 000 000  000000 000 000 000 00  000 00 000 000  0 000 000  000 000 500 1110
110 340 00 00 000 000  000000 000 000 000 00  000 00 000 000  1 341 600  000 000 400 1110
101 344 00 00 000 000  000000 000 000 000 00  000 00 000 000  0 000 000  000 000 340 1110
000 000 00 00 000 000  000000 000 000 000 00  000 00 000 000  1 300 777  000 000 000 1000
110 350 00 00 000 000  000000 000 000 000 00  000 00 000 000  0 000 000  000 000 400 1110
101 354 00 00 000 000  000000 000 000 000 00  000 00 000 000  0 000 000  000 000 350 1110
000 000 00 00 000 000  000000 000 000 000 00  000 00 000 000  0 000 000  000 000 000 1000

// ==== verification/ctrl_tb.sv ====
module ctrl_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD  = 100;
    localparam int NF      = 22;   // fields per pattern line
    localparam int MAX_PAT = 64;

    logic                             clk;
    logic                             rst;
    logic                             id_valid;
    logic [pipe_ctrl_pkg::XLEN-1:0]   id_pc;
    logic [pipe_ctrl_pkg::REG_AW-1:0] rs1;
    logic [pipe_ctrl_pkg::REG_AW-1:0] rs2;
    logic [pipe_ctrl_pkg::XLEN-1:0]   rs1_value;
    logic [pipe_ctrl_pkg::XLEN-1:0]   rs2_value;
    logic                             ecall;
    logic                             mret;
    logic                             ex_valid;
    logic [pipe_ctrl_pkg::XLEN-1:0]   ex_pc;
    logic [pipe_ctrl_pkg::XLEN-1:0]   ex_imm;
    logic [pipe_ctrl_pkg::XLEN-1:0]   ex_result;
    logic [pipe_ctrl_pkg::REG_AW-1:0] ex_rd;
    logic                             ex_reg_wen;
    logic                             ex_mem_ren;
    logic                             jump;
    logic                             branch;
    logic                             fence_i;
    logic                             mem_valid;
    logic [pipe_ctrl_pkg::REG_AW-1:0] mem_rd;
    logic                             mem_reg_wen;
    logic                             mem_mem_ren;
    logic [pipe_ctrl_pkg::XLEN-1:0]   mem_alu_result;
    logic [pipe_ctrl_pkg::XLEN-1:0]   mem_rdata;
    logic                             csr_wen;
    logic [11:0]                      csr_addr;
    logic [pipe_ctrl_pkg::XLEN-1:0]   csr_wdata;
    logic [pipe_ctrl_pkg::XLEN-1:0]   ex_rs1_in;
    logic [pipe_ctrl_pkg::XLEN-1:0]   ex_rs2_in;
    logic                             id_ready;
    logic [pipe_ctrl_pkg::XLEN-1:0]   dnpc;
    logic                             dnpc_valid;
    logic                             id_flush;
    logic                             icache_clr;

    logic [31:0] pat [0:MAX_PAT*NF-1];   // NF words per pattern, file column order
    int          n_pat;
    bit          loaded;

    ctrl_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input string name,
                              input logic [pipe_ctrl_pkg::XLEN-1:0] expected,
                              input logic [pipe_ctrl_pkg::XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic load_patterns();
        int    fd;
        int    cnt;
        int    b;
        string line;
        fd = $fopen("verification/ctrl_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file verification/ctrl_patterns.txt");
            abort_run();
        end
        n_pat = 0;
        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (cnt == 0 || line.len() < 2 || line.getc(0) == "#")
                continue;   // blank or comment line
            if (n_pat == MAX_PAT) begin
                $display("the pattern file holds more than %0d patterns", MAX_PAT);
                abort_run();
            end
            b = n_pat * NF;
            cnt = $sscanf(line,
                          "%b %h %h %h %h %h %b %h %h %h %h %b %h %h %h %b %h %h %h %h %h %b",
                          pat[b],    pat[b+1],  pat[b+2],  pat[b+3],  pat[b+4],  pat[b+5],
                          pat[b+6],  pat[b+7],  pat[b+8],  pat[b+9],  pat[b+10], pat[b+11],
                          pat[b+12], pat[b+13], pat[b+14], pat[b+15], pat[b+16], pat[b+17],
                          pat[b+18], pat[b+19], pat[b+20], pat[b+21]);
            if (cnt != NF) begin
                $display("pattern %0d does not hold %0d fields: %s", n_pat + 1, NF, line);
                abort_run();
            end
            n_pat++;
        end
        $fclose(fd);
        if (n_pat == 0) begin
            $display("the pattern file holds no patterns");
            abort_run();
        end
        loaded = 1'b1;
    endtask

    task automatic drive_pattern(input int i);
        int b;
        b = i * NF;
        {id_valid, ecall, mret} <= pat[b][2:0];
        id_pc                   <= pat[b+1];
        rs1                     <= pat[b+2][pipe_ctrl_pkg::REG_AW-1:0];
        rs2                     <= pat[b+3][pipe_ctrl_pkg::REG_AW-1:0];
        rs1_value               <= pat[b+4];
        rs2_value               <= pat[b+5];
        {ex_valid, ex_reg_wen, ex_mem_ren, jump, branch, fence_i} <= pat[b+6][5:0];
        ex_pc                   <= pat[b+7];
        ex_imm                  <= pat[b+8];
        ex_result               <= pat[b+9];
        ex_rd                   <= pat[b+10][pipe_ctrl_pkg::REG_AW-1:0];
        {mem_valid, mem_reg_wen, mem_mem_ren} <= pat[b+11][2:0];
        mem_rd                  <= pat[b+12][pipe_ctrl_pkg::REG_AW-1:0];
        mem_alu_result          <= pat[b+13];
        mem_rdata               <= pat[b+14];
        csr_wen                 <= pat[b+15][0];
        csr_addr                <= pat[b+16][11:0];
        csr_wdata               <= pat[b+17];
    endtask

    task automatic check_pattern(input int i);
        int b;
        b = i * NF;
        check_word("ex_rs1_in", pat[b+18], ex_rs1_in);
        check_word("ex_rs2_in", pat[b+19], ex_rs2_in);
        check_word("dnpc", pat[b+20], dnpc);
        check_bit("id_ready", pat[b+21][3], id_ready);
        check_bit("dnpc_valid", pat[b+21][2], dnpc_valid);
        check_bit("id_flush", pat[b+21][1], id_flush);
        check_bit("icache_clr", pat[b+21][0], icache_clr);
    endtask

    initial begin
        rst = 1'b1;
        {id_valid, id_pc, rs1, rs2, rs1_value, rs2_value, ecall, mret} = '0;
        {ex_valid, ex_pc, ex_imm, ex_result, ex_rd, ex_reg_wen, ex_mem_ren} = '0;
        {jump, branch, fence_i, mem_valid, mem_rd, mem_reg_wen, mem_mem_ren} = '0;
        {mem_alu_result, mem_rdata, csr_wen, csr_addr, csr_wdata} = '0;
        load_patterns();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < n_pat; i++) begin
            @(posedge clk);
            drive_pattern(i);
            #(PERIOD - 10);   // just before the next edge
            check_pattern(i);
        end
        $display("*** PASSED ***");
        $finish;
    end

    // watchdog, scaled to the pattern count
    initial begin
        wait (loaded);
        #((n_pat + 10) * PERIOD);
        $display("timeout: the pattern run did not end within %0d cycles", n_pat + 10);
        abort_run();
    end

endmodule

// ==== verilog/ctrl_top.sv ====
module ctrl_top (
    input  logic                             clk,
    input  logic                             rst,

    // id stage
    input  logic                             id_valid,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]   id_pc,
    input  logic [pipe_ctrl_pkg::REG_AW-1:0] rs1,
    input  logic [pipe_ctrl_pkg::REG_AW-1:0] rs2,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]   rs1_value,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]   rs2_value,
    input  logic                             ecall,
    input  logic                             mret,

    // ex stage
    input  logic                             ex_valid,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]   ex_pc,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]   ex_imm,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]   ex_result,
    input  logic [pipe_ctrl_pkg::REG_AW-1:0] ex_rd,
    input  logic                             ex_reg_wen,
    input  logic                             ex_mem_ren,
    input  logic                             jump,
    input  logic                             branch,
    input  logic                             fence_i,

    // mem stage
    input  logic                             mem_valid,
    input  logic [pipe_ctrl_pkg::REG_AW-1:0] mem_rd,
    input  logic                             mem_reg_wen,
    input  logic                             mem_mem_ren,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]   mem_alu_result,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]   mem_rdata,

    // csr write port
    input  logic                             csr_wen,
    input  logic [11:0]                      csr_addr,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]   csr_wdata,

    output logic [pipe_ctrl_pkg::XLEN-1:0]   ex_rs1_in,
    output logic [pipe_ctrl_pkg::XLEN-1:0]   ex_rs2_in,
    output logic                             id_ready,
    output logic [pipe_ctrl_pkg::XLEN-1:0]   dnpc,
    output logic                             dnpc_valid,
    output logic                             id_flush,
    output logic                             icache_clr
);

    logic [pipe_ctrl_pkg::XLEN-1:0] mtvec;
    logic [pipe_ctrl_pkg::XLEN-1:0] mepc;
    logic                           trap_take;

    pipe_control u_pipe_control (
        .id_valid       (id_valid),
        .rs1            (rs1),
        .rs2            (rs2),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .ecall          (ecall),
        .mret           (mret),
        .ex_valid       (ex_valid),
        .ex_pc          (ex_pc),
        .ex_imm         (ex_imm),
        .ex_result      (ex_result),
        .ex_rd          (ex_rd),
        .ex_reg_wen     (ex_reg_wen),
        .ex_mem_ren     (ex_mem_ren),
        .jump           (jump),
        .branch         (branch),
        .fence_i        (fence_i),
        .mem_valid      (mem_valid),
        .mem_rd         (mem_rd),
        .mem_reg_wen    (mem_reg_wen),
        .mem_mem_ren    (mem_mem_ren),
        .mem_alu_result (mem_alu_result),
        .mem_rdata      (mem_rdata),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .ex_rs1_in      (ex_rs1_in),
        .ex_rs2_in      (ex_rs2_in),
        .dnpc           (dnpc),
        .dnpc_valid     (dnpc_valid),
        .id_flush       (id_flush),
        .icache_clr     (icache_clr),
        .id_ready       (id_ready),
        .trap_take      (trap_take)
    );

    // mepc captures the pc of the ecall still sitting in id
    trap_csr u_trap_csr (
        .clk       (clk),
        .rst       (rst),
        .trap_take (trap_take),
        .id_pc     (id_pc),
        .csr_wen   (csr_wen),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .mtvec     (mtvec),
        .mepc      (mepc)
    );

endmodule

// ==== verilog/hazard_detect.sv ====
module hazard_detect (
    input  logic [pipe_ctrl_pkg::REG_AW-1:0] rs1,
    input  logic [pipe_ctrl_pkg::REG_AW-1:0] rs2,
    input  logic [pipe_ctrl_pkg::REG_AW-1:0] ex_rd,
    input  logic [pipe_ctrl_pkg::REG_AW-1:0] mem_rd,

    input  logic                             id_valid,
    input  logic                             ex_valid,
    input  logic                             mem_valid,
    input  logic                             ex_reg_wen,
    input  logic                             mem_reg_wen,
    input  logic                             ex_mem_ren,
    input  logic                             mem_mem_ren,

    output logic [pipe_ctrl_pkg::FWD_W-1:0]  rs1_sel,
    output logic [pipe_ctrl_pkg::FWD_W-1:0]  rs2_sel,
    output logic                             load_use
);

    logic ex_fwd_ok;    // ex stage holds a register write
    logic mem_fwd_ok;   // mem stage holds a register write
    logic ex_rd_nz;

    assign ex_fwd_ok  = ex_valid & ex_reg_wen;
    assign mem_fwd_ok = mem_valid & mem_reg_wen;
    assign ex_rd_nz   = (ex_rd != '0);

    // youngest producer wins, x0 never forwards
    function automatic logic [pipe_ctrl_pkg::FWD_W-1:0] fwd_select(
        input logic [pipe_ctrl_pkg::REG_AW-1:0] src,
        input logic [pipe_ctrl_pkg::REG_AW-1:0] ex_dst,
        input logic [pipe_ctrl_pkg::REG_AW-1:0] mem_dst,
        input logic                             ex_ok,
        input logic                             mem_ok,
        input logic                             mem_load
    );
        logic [pipe_ctrl_pkg::FWD_W-1:0] sel;
        sel = pipe_ctrl_pkg::FWD_RF;
        if (src == '0) begin
            sel = pipe_ctrl_pkg::FWD_RF;
        end else if (ex_ok && (src == ex_dst)) begin
            sel = pipe_ctrl_pkg::FWD_EX;
        end else if (mem_ok && (src == mem_dst)) begin
            // a load in mem has its data back already
            sel = mem_load ? pipe_ctrl_pkg::FWD_MEM_LOAD : pipe_ctrl_pkg::FWD_MEM_ALU;
        end
        return sel;
    endfunction

    assign rs1_sel = fwd_select(rs1, ex_rd, mem_rd, ex_fwd_ok, mem_fwd_ok, mem_mem_ren);
    assign rs2_sel = fwd_select(rs2, ex_rd, mem_rd, ex_fwd_ok, mem_fwd_ok, mem_mem_ren);

    // load in ex has no data yet, so the consumer in id must wait a cycle
    assign load_use = id_valid & ex_valid & ex_mem_ren & ex_rd_nz &
                      ((rs1 == ex_rd) | (rs2 == ex_rd));

endmodule

// ==== verilog/pipe_control.sv ====
module pipe_control (
    // id stage
    input  logic                            id_valid,
    input  logic [pipe_ctrl_pkg::REG_AW-1:0] rs1,
    input  logic [pipe_ctrl_pkg::REG_AW-1:0] rs2,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]  rs1_value,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]  rs2_value,
    input  logic                            ecall,
    input  logic                            mret,

    // ex stage
    input  logic                            ex_valid,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]  ex_pc,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]  ex_imm,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]  ex_result,
    input  logic [pipe_ctrl_pkg::REG_AW-1:0] ex_rd,
    input  logic                            ex_reg_wen,
    input  logic                            ex_mem_ren,
    input  logic                            jump,
    input  logic                            branch,
    input  logic                            fence_i,

    // mem stage
    input  logic                            mem_valid,
    input  logic [pipe_ctrl_pkg::REG_AW-1:0] mem_rd,
    input  logic                            mem_reg_wen,
    input  logic                            mem_mem_ren,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]  mem_alu_result,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]  mem_rdata,

    // trap registers
    input  logic [pipe_ctrl_pkg::XLEN-1:0]  mtvec,
    input  logic [pipe_ctrl_pkg::XLEN-1:0]  mepc,

    output logic [pipe_ctrl_pkg::XLEN-1:0]  ex_rs1_in,
    output logic [pipe_ctrl_pkg::XLEN-1:0]  ex_rs2_in,
    output logic [pipe_ctrl_pkg::XLEN-1:0]  dnpc,
    output logic                            dnpc_valid,
    output logic                            id_flush,
    output logic                            icache_clr,
    output logic                            id_ready,
    output logic                            trap_take
);

    logic [pipe_ctrl_pkg::FWD_W-1:0] rs1_sel;
    logic [pipe_ctrl_pkg::FWD_W-1:0] rs2_sel;
    logic                            load_use;

    logic                            branch_taken;
    logic                            ex_redirect;
    logic                            id_redirect;
    logic [pipe_ctrl_pkg::XLEN-1:0]  ex_target;
    logic [pipe_ctrl_pkg::XLEN-1:0]  id_target;

    hazard_detect u_hazard_detect (
        .rs1         (rs1),
        .rs2         (rs2),
        .ex_rd       (ex_rd),
        .mem_rd      (mem_rd),
        .id_valid    (id_valid),
        .ex_valid    (ex_valid),
        .mem_valid   (mem_valid),
        .ex_reg_wen  (ex_reg_wen),
        .mem_reg_wen (mem_reg_wen),
        .ex_mem_ren  (ex_mem_ren),
        .mem_mem_ren (mem_mem_ren),
        .rs1_sel     (rs1_sel),
        .rs2_sel     (rs2_sel),
        .load_use    (load_use)
    );

    assign branch_taken = branch & ex_result[0];   // alu leaves the compare in bit 0
    assign ex_redirect  = ex_valid & (jump | branch_taken | fence_i);
    assign id_redirect  = id_valid & (ecall | mret) & ~ex_redirect;  // ex is older
    assign trap_take    = id_redirect & ecall & ~mret;

    assign ex_target = jump         ? ex_result :
                       branch_taken ? ex_pc + ex_imm :
                                      ex_pc + 32'd4;   // fence.i refetches the next pc
    assign id_target = mret ? mepc : mtvec;

    assign dnpc       = ex_redirect ? ex_target :
                        id_redirect ? id_target : '0;
    assign dnpc_valid = ex_redirect | id_redirect;
    assign id_flush   = ex_redirect | id_redirect;
    assign icache_clr = ex_valid & fence_i;
    assign id_ready   = ~load_use;   // stall id, bubble into ex

    function automatic logic [pipe_ctrl_pkg::XLEN-1:0] fwd_mux(
        input logic [pipe_ctrl_pkg::FWD_W-1:0] sel,
        input logic [pipe_ctrl_pkg::XLEN-1:0]  rf_value
    );
        logic [pipe_ctrl_pkg::XLEN-1:0] value;
        case (sel)
            pipe_ctrl_pkg::FWD_EX:       value = ex_result;
            pipe_ctrl_pkg::FWD_MEM_ALU:  value = mem_alu_result;
            pipe_ctrl_pkg::FWD_MEM_LOAD: value = mem_rdata;
            default:                     value = rf_value;
        endcase
        return value;
    endfunction

    assign ex_rs1_in = fwd_mux(rs1_sel, rs1_value);
    assign ex_rs2_in = fwd_mux(rs2_sel, rs2_value);

endmodule

// ==== verilog/pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

    // datapath widths
    localparam int XLEN   = 32;   // data and pc width
    localparam int REG_AW = 5;    // register index width
    localparam int FWD_W  = 2;

    // forward select codes, one per operand
    localparam logic [FWD_W-1:0] FWD_RF       = 2'd0;  // register file value
    localparam logic [FWD_W-1:0] FWD_EX       = 2'd1;  // ex stage result
    localparam logic [FWD_W-1:0] FWD_MEM_ALU  = 2'd2;  // mem stage alu result
    localparam logic [FWD_W-1:0] FWD_MEM_LOAD = 2'd3;  // mem stage load data

    // machine mode csr addresses
    localparam logic [11:0] CSR_MTVEC = 12'h305;
    localparam logic [11:0] CSR_MEPC  = 12'h341;

    // trap register values after reset
    localparam logic [XLEN-1:0] MTVEC_RESET = 32'h0000_0100;
    localparam logic [XLEN-1:0] MEPC_RESET  = 32'h0000_0000;

endpackage

// ==== verilog/trap_csr.sv ====
module trap_csr (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           trap_take,  // ecall accepted this cycle
    input  logic [pipe_ctrl_pkg::XLEN-1:0] id_pc,

    input  logic                           csr_wen,
    input  logic [11:0]                    csr_addr,
    input  logic [pipe_ctrl_pkg::XLEN-1:0] csr_wdata,

    output logic [pipe_ctrl_pkg::XLEN-1:0] mtvec,
    output logic [pipe_ctrl_pkg::XLEN-1:0] mepc
);

    logic mtvec_we;
    logic mepc_we;

    // csr address decode
    assign mtvec_we = csr_wen & (csr_addr == pipe_ctrl_pkg::CSR_MTVEC);
    assign mepc_we  = csr_wen & (csr_addr == pipe_ctrl_pkg::CSR_MEPC);

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec <= pipe_ctrl_pkg::MTVEC_RESET;
        end else if (mtvec_we) begin
            mtvec <= csr_wdata;
        end
    end

    // trap capture beats a software write in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mepc <= pipe_ctrl_pkg::MEPC_RESET;
        end else if (trap_take) begin
            mepc <= id_pc;   // pc of the ecall itself
        end else if (mepc_we) begin
            mepc <= csr_wdata;
        end
    end

endmodule

// ==== vlog.f ====
verilog/pipe_ctrl_pkg.sv
verilog/hazard_detect.sv
verilog/pipe_control.sv
verilog/trap_csr.sv
verilog/ctrl_top.sv
verification/ctrl_tb.sv
